// ==== Bender.yml ====
package:
  name: uart_mem

sources:
  - uart_mem_pkg.sv
  - uart_rx.sv
  - uart_tx.sv
  - chan_framer.sv
  - mem_server.sv
  - uart_mem_top.sv
  - target: test
    files:
      - uart_mem_sva.sv
      - uart_mem_tb.sv

// ==== chan_framer.sv ====
`timescale 1ns/1ps

module chan_framer import uart_mem_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [7:0] rx_byte,
	input logic rx_valid,
	output msg_t req_msg,
	output logic req_valid,
	input logic req_ready,
	input msg_t reply_msg,
	input logic reply_valid,
	output logic reply_ready,
	output logic [7:0] tx_data,
	output logic tx_valid,
	input logic tx_ready
);

	////////////////////////////////////////////////////////////
	// Receive side
	////////////////////////////////////////////////////////////

	frame_state_t state;
	msg_t rx_msg;
	msg_len_t rx_idx;

	assign req_msg = rx_msg;
	assign req_valid = (state == FR_HOLD);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= FR_HEADER;
			rx_msg <= '0;
			rx_idx <= '0;
		end else begin
			case (state)
				FR_HEADER: begin
					// Empty messages are skipped
					if (rx_valid && rx_byte[4:0] != 5'd0) begin
						rx_msg.chan <= rx_byte[7];
						rx_msg.len <= rx_byte[4:0];
						rx_msg.payload <= '0;
						rx_idx <= '0;
						state <= FR_PAYLOAD;
					end
				end
				FR_PAYLOAD: begin
					if (rx_valid) begin
						// Bytes past the ninth are counted but not kept
						if (rx_idx < msg_len_t'(MAX_PAYLOAD))
							rx_msg.payload[rx_idx*8 +: 8] <= rx_byte;
						rx_idx <= rx_idx + 1'b1;
						if (rx_idx == rx_msg.len - 1'b1)
							state <= rx_msg.chan ? FR_HEADER : FR_HOLD;
					end
				end
				FR_HOLD: begin
					if (req_ready)
						state <= FR_HEADER;
				end
				default: state <= FR_HEADER;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Transmit side
	////////////////////////////////////////////////////////////

	logic tx_busy;
	msg_len_t tx_idx;
	msg_len_t tx_len;
	logic [7:0] tx_hdr;
	logic [PAYLOAD_W-1:0] tx_pay;
	logic tx_fire;

	assign reply_ready = !tx_busy;
	assign tx_valid = tx_busy;
	assign tx_fire = tx_valid && tx_ready;

	// Index 0 is the header, payload follows from the low byte
	assign tx_data = (tx_idx == 5'd0) ? tx_hdr : tx_pay[7:0];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tx_busy <= 1'b0;
			tx_idx <= '0;
		end else if (reply_valid && reply_ready) begin
			tx_busy <= 1'b1;
			tx_idx <= '0;
		end else if (tx_fire) begin
			tx_idx <= tx_idx + 1'b1;
			if (tx_idx == tx_len)
				tx_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reply_valid && reply_ready) begin
			tx_hdr <= {reply_msg.chan, 2'b00, reply_msg.len};
			tx_len <= reply_msg.len;
			tx_pay <= reply_msg.payload;
		end else if (tx_fire && tx_idx != 5'd0) begin
			tx_pay <= tx_pay >> 8;
		end
	end

endmodule

// ==== mem_server.sv ====
`timescale 1ns/1ps

module mem_server import uart_mem_pkg::*; (
	input logic clk,
	input logic rst,
	input msg_t req_msg,
	input logic req_valid,
	output logic req_ready,
	output msg_t reply_msg,
	output logic reply_valid,
	input logic reply_ready
);

	// Contents start at zero
	logic [7:0] mem [MEM_BYTES] = '{default: 8'h00};
	mem_req_t req;
	data_word_t rdata;
	logic accept;

	// Each byte of a word wraps on its own
	function automatic logic [MEM_AW-1:0] lane_addr(
		input logic [31:0] base,
		input logic [1:0] lane
	);
		lane_addr = base[MEM_AW-1:0] + MEM_AW'(lane);
	endfunction

	////////////////////////////////////////////////////////////
	// Request decode
	////////////////////////////////////////////////////////////

	always_comb begin
		req = '0;
		if (req_msg.len == READ_LEN && !req_msg.payload[32]) begin
			req.op = MEM_READ;
			req.addr = req_msg.payload[31:0];
		end else begin
			// Write layout is data, then address, then mask
			req.op = MEM_WRITE;
			req.wdata = req_msg.payload[31:0];
			req.addr = req_msg.payload[63:32];
			req.mask = req_msg.payload[67:64];
		end
	end

	// Only one reply can wait at a time
	assign req_ready = !reply_valid;
	assign accept = req_valid && req_ready;

	////////////////////////////////////////////////////////////
	// Byte array
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (accept && req.op == MEM_WRITE) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (req.mask[lane])
					mem[lane_addr(req.addr, 2'(lane))] <= req.wdata[lane*8 +: 8];
			end
		end
		if (accept && req.op == MEM_READ) begin
			rdata <= {mem[lane_addr(req.addr, 2'd3)],
				mem[lane_addr(req.addr, 2'd2)],
				mem[lane_addr(req.addr, 2'd1)],
				mem[lane_addr(req.addr, 2'd0)]};
		end
	end

	////////////////////////////////////////////////////////////
	// Reply
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			reply_valid <= 1'b0;
		else if (accept && req.op == MEM_READ)
			reply_valid <= 1'b1;
		else if (reply_ready)
			reply_valid <= 1'b0;
	end

	// Little-endian word on channel 0
	always_comb begin
		reply_msg = '0;
		reply_msg.chan = 1'b0;
		reply_msg.len = REPLY_LEN;
		reply_msg.payload[31:0] = rdata;
	end

endmodule

// ==== uart_mem.f ====
uart_mem_pkg.sv
uart_rx.sv
uart_tx.sv
chan_framer.sv
mem_server.sv
uart_mem_top.sv
uart_mem_sva.sv
uart_mem_tb.sv

// ==== uart_mem_pkg.sv ====
package uart_mem_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////

	// Serial bit period in clock cycles
	localparam int CLKS_PER_BIT = 16;
	localparam int BAUD_CW = $clog2(CLKS_PER_BIT);

	localparam int MEM_BYTES = 2048;
	localparam int MEM_AW = 11;

	// Longest payload is a write: data, address, mask
	localparam int MAX_PAYLOAD = 9;
	localparam int PAYLOAD_W = MAX_PAYLOAD * 8;

	typedef logic [4:0] msg_len_t;

	localparam msg_len_t READ_LEN = 5'd5;
	localparam msg_len_t REPLY_LEN = 5'd4;

	typedef logic [31:0] data_word_t;
	typedef logic [3:0] byte_mask_t;

	////////////////////////////////////////////////////////////
	// Opcodes and states
	////////////////////////////////////////////////////////////

	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} mem_op_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	typedef enum logic [1:0] {
		FR_HEADER,
		FR_PAYLOAD,
		FR_HOLD
	} frame_state_t;

	////////////////////////////////////////////////////////////
	// Messages
	////////////////////////////////////////////////////////////

	// Payload byte 0 sits in bits 7:0
	typedef struct packed {
		logic chan;
		msg_len_t len;
		logic [PAYLOAD_W-1:0] payload;
	} msg_t;

	typedef struct packed {
		mem_op_t op;
		logic [31:0] addr;
		data_word_t wdata;
		byte_mask_t mask;
	} mem_req_t;

endpackage

// ==== uart_mem_sva.sv ====
`timescale 1ns/1ps

module uart_mem_sva import uart_mem_pkg::*; (
	input logic clk,
	input logic rst,
	input logic tx,
	input msg_t req_msg,
	input logic req_valid,
	input logic req_ready,
	input msg_t reply_msg,
	input logic reply_valid,
	input logic reply_ready,
	input logic [7:0] tx_data,
	input logic tx_valid,
	input logic tx_ready
);

	// Number of failed assertions
	int fail_count = 0;

	// Line idles high through reset
	tx_idle_in_reset: assert property (@(posedge clk) rst |-> tx)
		else begin
			$error("tx low while rst is high");
			fail_count++;
		end

	req_hold: assert property (@(posedge clk) disable iff (rst)
		req_valid && !req_ready |=> req_valid && $stable(req_msg))
		else begin
			$error("request dropped or changed before req_ready");
			fail_count++;
		end

	reply_hold: assert property (@(posedge clk) disable iff (rst)
		reply_valid && !reply_ready |=> reply_valid && $stable(reply_msg))
		else begin
			$error("reply dropped or changed before reply_ready");
			fail_count++;
		end

	tx_hold: assert property (@(posedge clk) disable iff (rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
		else begin
			$error("tx byte dropped or changed before tx_ready");
			fail_count++;
		end

endmodule

bind uart_mem_top uart_mem_sva u_sva (
	.clk(clk),
	.rst(rst),
	.tx(tx),
	.req_msg(req_msg),
	.req_valid(req_valid),
	.req_ready(req_ready),
	.reply_msg(reply_msg),
	.reply_valid(reply_valid),
	.reply_ready(reply_ready),
	.tx_data(tx_data),
	.tx_valid(tx_valid),
	.tx_ready(tx_ready)
);

// ==== uart_mem_tb.sv ====
`timescale 1ns/1ps

module uart_mem_tb import uart_mem_pkg::*; ();

	logic clk;
	logic rst;
	logic rx;
	logic tx;
	int errors;
	int checks;
	int seed;
	logic [7:0] model_mem [MEM_BYTES];
	logic [7:0] reply_q [$];

	uart_mem_top UUT (
		.clk(clk),
		.rst(rst),
		.rx(rx),
		.tx(tx)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Serial driver and monitor
	////////////////////////////////////////////////////////////

	// Inputs change and outputs are read 1 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic hold_bit();
		repeat (CLKS_PER_BIT) next_cycle();
	endtask

	task automatic send_byte(input logic [7:0] b);
		rx = 1'b0;
		hold_bit();
		for (int i = 0; i < 8; i++) begin
			rx = b[i];
			hold_bit();
		end
		rx = 1'b1;
		hold_bit();
	endtask

	// Decodes every byte on tx into reply_q
	always begin : tx_monitor
		logic [7:0] b;
		next_cycle();
		if (!rst && tx === 1'b0) begin
			repeat (CLKS_PER_BIT / 2) next_cycle();
			if (tx !== 1'b0) begin
				$display("start bit on tx too short at %0t", $time);
				errors++;
			end
			for (int i = 0; i < 8; i++) begin
				hold_bit();
				b[i] = tx;
			end
			hold_bit();
			if (tx !== 1'b1) begin
				$display("bad stop bit on tx at %0t", $time);
				errors++;
			end else begin
				reply_q.push_back(b);
			end
		end
	end

	task automatic recv_byte(output logic [7:0] b, output logic ok);
		int waited;
		waited = 0;
		b = 8'h00;
		while (reply_q.size() == 0 && waited < 40 * CLKS_PER_BIT) begin
			next_cycle();
			waited++;
		end
		ok = (reply_q.size() != 0);
		if (ok) begin
			b = reply_q.pop_front();
		end else begin
			$display("no reply byte within timeout at %0t", $time);
			errors++;
		end
	endtask

	task automatic expect_silence(input int cycles);
		logic quiet;
		quiet = 1'b1;
		for (int i = 0; i < cycles; i++) begin
			next_cycle();
			if (tx !== 1'b1)
				quiet = 1'b0;
		end
		if (!quiet || reply_q.size() != 0) begin
			$display("unexpected reply on tx at %0t", $time);
			errors++;
			reply_q.delete();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Framing and reference model
	////////////////////////////////////////////////////////////

	task automatic send_frame(input logic [7:0] hdr, input logic [71:0] pay, input int len);
		send_byte(hdr);
		for (int i = 0; i < len; i++)
			send_byte(pay[i*8 +: 8]);
	endtask

	task automatic send_write(input logic [31:0] addr, input data_word_t data,
		input byte_mask_t mask);
		send_frame({3'b000, 5'd9}, {4'h0, mask, addr, data}, 9);
		for (int lane = 0; lane < 4; lane++) begin
			if (mask[lane])
				model_mem[(int'(addr[MEM_AW-1:0]) + lane) % MEM_BYTES] = data[lane*8 +: 8];
		end
	endtask

	task automatic send_read(input logic [31:0] addr);
		send_frame({3'b000, READ_LEN}, {40'h0, addr}, 5);
	endtask

	function automatic data_word_t model_read(input logic [31:0] addr);
		data_word_t w;
		for (int lane = 0; lane < 4; lane++)
			w[lane*8 +: 8] = model_mem[(int'(addr[MEM_AW-1:0]) + lane) % MEM_BYTES];
		return w;
	endfunction

	task automatic check_data(input data_word_t got, input data_word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("** Error at %0t: %s data got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_len(input msg_len_t got, input msg_len_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("** Error at %0t: %s length got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic read_check(input logic [31:0] addr, input string what);
		logic [7:0] hdr;
		logic [7:0] b;
		logic ok;
		data_word_t got;
		send_read(addr);
		recv_byte(hdr, ok);
		if (!ok)
			return;
		checks++;
		if (hdr[7]) begin
			$display("** Error at %0t: reply for %s came on channel 1", $time, what);
			errors++;
		end
		// A read reply carries one 4-byte word
		check_len(msg_len_t'(hdr[4:0]), 5'd4, what);
		got = '0;
		for (int i = 0; i < 4; i++) begin
			recv_byte(b, ok);
			if (!ok)
				return;
			got[i*8 +: 8] = b;
		end
		check_data(got, model_read(addr), what);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic reset_and_unwritten_read();
		expect_silence(20 * CLKS_PER_BIT);
		read_check(32'h0000_0100, "unwritten word");
	endtask

	task automatic full_write_read();
		send_write(32'h0000_0020, 32'h1234_5678, 4'hf);
		expect_silence(20 * CLKS_PER_BIT);
		read_check(32'h0000_0020, "full mask write");
	endtask

	task automatic partial_mask_merge();
		send_write(32'h0000_0040, 32'h1122_3344, 4'b0101);
		send_write(32'h0000_0040, 32'haabb_ccdd, 4'b1010);
		read_check(32'h0000_0040, "merged masks");
	endtask

	task automatic address_wrap();
		// Upper address bits ignored so this lands at 2046
		send_write(32'hffff_f7fe, 32'hdead_beef, 4'hf);
		read_check(32'h0000_0000, "wrap read at 0");
		read_check(32'h0000_07fe, "wrap read at 2046");
		read_check(32'h0000_07ff, "unaligned read at 2047");
	endtask

	task automatic channel1_dropped();
		send_frame({3'b100, READ_LEN}, {40'h0, 32'h0000_07fe}, 5);
		expect_silence(20 * CLKS_PER_BIT);
		read_check(32'h0000_07fe, "read after channel 1");
	endtask

	task automatic random_write_read();
		logic [31:0] addr;
		data_word_t data;
		byte_mask_t mask;
		for (int n = 0; n < 40; n++) begin
			addr = $random(seed);
			data = $random(seed);
			mask = $random(seed);
			send_write(addr, data, mask);
			read_check(addr, "random access");
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		rx = 1'b1;
		errors = 0;
		checks = 0;
		seed = 88;
		foreach (model_mem[i])
			model_mem[i] = 8'h00;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_and_unwritten_read();
		full_write_read();
		partial_mask_merge();
		address_wrap();
		channel1_dropped();
		random_write_read();
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, UUT.u_sva.fail_count);
		if (errors == 0 && UUT.u_sva.fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Overall limit on the run
	initial begin
		#20ms;
		$display("simulation timed out before the tests finished");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== uart_mem_top.sv ====
`timescale 1ns/1ps

module uart_mem_top import uart_mem_pkg::*; (
	input logic clk,
	input logic rst,
	input logic rx,
	output logic tx
);

	logic [7:0] rx_byte;
	logic rx_valid;
	msg_t req_msg;
	logic req_valid;
	logic req_ready;
	msg_t reply_msg;
	logic reply_valid;
	logic reply_ready;
	logic [7:0] tx_data;
	logic tx_valid;
	logic tx_ready;

	uart_rx u_rx (
		.clk(clk),
		.rst(rst),
		.rx(rx),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid)
	);

	chan_framer u_framer (
		.clk(clk),
		.rst(rst),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.req_msg(req_msg),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.reply_msg(reply_msg),
		.reply_valid(reply_valid),
		.reply_ready(reply_ready),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready)
	);

	mem_server u_server (
		.clk(clk),
		.rst(rst),
		.req_msg(req_msg),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.reply_msg(reply_msg),
		.reply_valid(reply_valid),
		.reply_ready(reply_ready)
	);

	uart_tx u_tx (
		.clk(clk),
		.rst(rst),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx(tx)
	);

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import uart_mem_pkg::*; (
	input logic clk,
	input logic rst,
	input logic rx,
	output logic [7:0] rx_byte,
	output logic rx_valid
);

	rx_state_t state;
	logic rx_s1;
	logic rx_s2;
	logic [BAUD_CW-1:0] baud_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic bit_end;

	// Line idles high, so the synchronizer resets to one
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
		end else begin
			rx_s1 <= rx;
			rx_s2 <= rx_s1;
		end
	end

	// Mid-bit point of a data or stop bit
	assign bit_end = (baud_cnt == BAUD_CW'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (!rx_s2)
						state <= RX_START;
				end
				RX_START: begin
					// Recheck at half a bit to reject glitches
					if (baud_cnt == BAUD_CW'(CLKS_PER_BIT / 2 - 1)) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						state <= rx_s2 ? RX_IDLE : RX_DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_end) begin
						state <= RX_IDLE;
						rx_valid <= rx_s2;  // bad stop bit drops the byte
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first, shift in from the top
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end)
			shift <= {rx_s2, shift[7:1]};
		if (state == RX_STOP && bit_end && rx_s2)
			rx_byte <= shift;
	end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import uart_mem_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [7:0] tx_data,
	input logic tx_valid,
	output logic tx_ready,
	output logic tx
);

	tx_state_t state;
	logic [BAUD_CW-1:0] baud_cnt;
	logic [2:0] bit_idx;
	logic [7:0] data_q;
	logic bit_end;

	assign tx_ready = (state == TX_IDLE);
	assign bit_end = (baud_cnt == BAUD_CW'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= TX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			tx <= 1'b1;
		end else begin
			baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					baud_cnt <= '0;
					if (tx_valid) begin
						state <= TX_START;
						tx <= 1'b0;
					end
				end
				TX_START: begin
					if (bit_end) begin
						state <= TX_DATA;
						bit_idx <= '0;
						tx <= data_q[0];
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							state <= TX_STOP;
							tx <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx <= data_q[bit_idx + 3'd1];
						end
					end
				end
				TX_STOP: begin
					if (bit_end)
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (tx_valid && tx_ready)
			data_q <= tx_data;
	end

endmodule
